/* tb.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/hazardUnit.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/dataMemory.sv
verilog/pipeCore.sv
tests/pipeCoreTb.sv

/* tests/pipeCoreTb.sv */
`include "pipeCore_cfg.svh"

module pipeCoreTb;
    import pipePkg::*;

    localparam int ResetCycles = 8;
    localparam int InputSkew   = 1;     // Drive delay after the rising edge
    localparam int MemIdxW     = $clog2(`DMEM_WORDS);

    logic             clk = 1'b0;
    logic             rst;
    logic [`XLEN-1:0] imemAddr;
    logic [`XLEN-1:0] imemData;
    retire_t          retire;

    logic [31:0]      rom [$];          // Program, one word per entry
    logic [`XLEN-1:0] modelRegs [32];
    logic [`XLEN-1:0] modelMem [`DMEM_WORDS];
    logic [`XLEN-1:0] modelPc;
    logic [`XLEN-1:0] haltPc;
    retire_t          expected;
    logic             finished;
    int               cycles;
    int               cycleLimit;

    pipeCore i_dut (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData), .retire(retire)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] aluR(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    // I-type, used for ADDI and LW
    function automatic logic [31:0] immOp(input int imm, input int rs1, input int f3,
                                          input int rd, input int opcode);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic logic [31:0] store(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchEq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Words past the program read as ADDI x0, x0, 0
    function automatic logic [31:0] fetchWord(input logic [`XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] == 2'b00 && idx < rom.size())
            return rom[idx];
        return 32'h0000_0013;
    endfunction

    task automatic loadProgram();
        rom.push_back(immOp(int'($urandom), 0, 0, 1, 7'h13));  // addi x1, x0, rnd
        rom.push_back(immOp(int'($urandom), 0, 0, 2, 7'h13));  // addi x2, x0, rnd
        rom.push_back(aluR(7'h00, 3'b000, 3, 1, 2));           // add x3, x1, x2
        rom.push_back(aluR(7'h20, 3'b000, 4, 3, 1));           // sub x4, x3, x1
        rom.push_back(aluR(7'h00, 3'b100, 3, 3, 4));           // xor x3, x3, x4
        rom.push_back(aluR(7'h00, 3'b110, 3, 3, 3));           // or x3, x3, x3
        rom.push_back(aluR(7'h00, 3'b111, 5, 3, 1));           // and x5, x3, x1 (mem and wb hit)
        rom.push_back(aluR(7'h00, 3'b010, 6, 4, 5));           // slt x6, x4, x5
        rom.push_back(aluR(7'h00, 3'b010, 7, 5, 4));           // slt x7, x5, x4
        rom.push_back(immOp(7, 1, 0, 0, 7'h13));               // addi x0, x1, 7
        rom.push_back(aluR(7'h00, 3'b000, 8, 0, 0));           // add x8, x0, x0
        rom.push_back(aluR(7'h00, 3'b110, 9, 0, 2));           // or x9, x0, x2
        rom.push_back(immOp(16, 0, 0, 10, 7'h13));             // addi x10, x0, 16
        rom.push_back(store(3, 10, 0));                        // sw x3, 0(x10)
        rom.push_back(immOp(0, 10, 2, 11, 7'h03));             // lw x11, 0(x10)
        rom.push_back(aluR(7'h00, 3'b000, 12, 11, 1));         // add x12, x11, x1
        rom.push_back(store(12, 10, 4));                       // sw x12, 4(x10)
        rom.push_back(immOp(4, 10, 2, 13, 7'h03));             // lw x13, 4(x10)
        rom.push_back(aluR(7'h00, 3'b000, 14, 13, 13));        // add x14, x13, x13
        rom.push_back(branchEq(14, 14, 12));                   // beq x14, x14, +12 taken
        rom.push_back(immOp(1, 0, 0, 15, 7'h13));              // Wrong path
        rom.push_back(immOp(2, 0, 0, 16, 7'h13));              // Wrong path
        rom.push_back(jump(17, 12));                           // jal x17, +12
        rom.push_back(immOp(3, 0, 0, 15, 7'h13));              // Wrong path
        rom.push_back(immOp(4, 0, 0, 16, 7'h13));              // Wrong path
        rom.push_back(aluR(7'h00, 3'b000, 18, 17, 0));         // add x18, x17, x0
        rom.push_back(branchEq(10, 0, 12));                    // beq x10, x0, +12 not taken
        rom.push_back(immOp(int'($urandom), 10, 0, 19, 7'h13)); // addi x19, x10, rnd
        rom.push_back(aluR(7'h00, 3'b000, 20, 19, 14));        // add x20, x19, x14
        rom.push_back(jump(0, 0));                             // Halt loop
    endtask

    // Reference ISA model, one instruction per retire
    task automatic modelRetire(output retire_t exp);
        logic [31:0]      instr;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] immI;
        logic [`XLEN-1:0] immS;
        logic [`XLEN-1:0] immB;
        logic [`XLEN-1:0] immJ;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] nextPc;
        logic [2:0]       f3;
        logic [6:0]       f7;
        instr  = fetchWord(modelPc);
        f3     = instr[14:12];
        f7     = instr[31:25];
        a      = modelRegs[instr[19:15]];
        b      = modelRegs[instr[24:20]];
        immI   = {{20{instr[31]}}, instr[31:20]};
        immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        nextPc = modelPc + 4;
        exp       = '0;
        exp.valid = 1'b1;
        exp.pc    = modelPc;
        exp.rd    = instr[11:7];
        case (instr[6:0])
            7'b0110011: if (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000)) begin
                exp.regWrite = 1'b1;
                case (f3)
                    3'b000:  exp.data = f7[5] ? a - b : a + b;
                    3'b010:  exp.data = ($signed(a) < $signed(b)) ? 1 : 0;
                    3'b100:  exp.data = a ^ b;
                    3'b110:  exp.data = a | b;
                    3'b111:  exp.data = a & b;
                    default: exp.regWrite = 1'b0;
                endcase
            end
            7'b0010011: if (f3 == 3'b000) begin
                exp.regWrite = 1'b1;
                exp.data     = a + immI;
            end
            7'b0000011: if (f3 == 3'b010) begin
                addr         = a + immI;
                exp.regWrite = 1'b1;
                exp.data     = modelMem[addr[MemIdxW+1:2]];
            end
            7'b0100011: if (f3 == 3'b010) begin
                addr = a + immS;
                modelMem[addr[MemIdxW+1:2]] = b;
            end
            7'b1100011: if (f3 == 3'b000 && a == b)
                nextPc = modelPc + immB;
            7'b1101111: begin
                exp.regWrite = 1'b1;
                exp.data     = modelPc + 4;         // Link value
                nextPc       = modelPc + immJ;
            end
            default: exp.regWrite = 1'b0;
        endcase
        if (exp.regWrite && exp.rd != '0)
            modelRegs[exp.rd] = exp.data;
        modelPc = nextPc;
    endtask

    task automatic abortRun();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string field, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        $display("MISMATCH at %0t: %s expected %h got %h", $time, field, expVal, gotVal);
        abortRun();
    endtask

    // ROM answers the current fetch address
    always @(posedge clk) begin
        #InputSkew imemData = fetchWord(imemAddr);
    end

    // Retire is stable mid-cycle
    always @(negedge clk) begin
        if (rst && cycles > 0) begin
            assert (retire.valid === 1'b0)
                else reportMismatch("retire.valid", 32'd0, 32'(retire.valid));
        end else if (!rst && retire.valid && !finished) begin
            modelRetire(expected);
            assert (retire.pc == expected.pc)
                else reportMismatch("retire.pc", expected.pc, retire.pc);
            assert (retire.rd == expected.rd)
                else reportMismatch("retire.rd", 32'(expected.rd), 32'(retire.rd));
            assert (retire.regWrite == expected.regWrite)
                else reportMismatch("retire.regWrite", 32'(expected.regWrite),
                                    32'(retire.regWrite));
            if (expected.regWrite)
                assert (retire.data == expected.data)
                    else reportMismatch("retire.data", expected.data, retire.data);
            if (expected.pc == haltPc)
                finished = 1'b1;
        end
    end

    initial begin
        void'($urandom(32'hb4a5_ca68));
        rst      = 1'b1;
        imemData = '0;
        finished = 1'b0;
        cycles   = 0;
        modelPc  = `RESET_PC;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        loadProgram();
        haltPc     = 32'((rom.size() - 1) * 4);
        cycleLimit = ResetCycles + rom.size() * (4 + `MEM_WAIT_CYCLES + 2) + 50;
        repeat (ResetCycles) begin
            @(posedge clk);
            cycles++;
        end
        #InputSkew rst = 1'b0;
        while (!finished && cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (finished) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Timeout: last instruction did not retire within %0d cycles", cycleLimit);
            abortRun();
        end
    end

endmodule

/* verilog/dataMemory.sv */
`include "pipeCore_cfg.svh"

module dataMemory (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  logic             write,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata,
    output logic             memStall
);
    localparam int IdxW = $clog2(`DMEM_WORDS);
    localparam int CntW = $clog2(`MEM_WAIT_CYCLES + 2);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [CntW-1:0]  waitLeft;     // Stall cycles still owed to this access
    logic             done;
    logic [IdxW-1:0]  wordIdx;

    assign wordIdx  = addr[IdxW+1:2];
    assign done     = (waitLeft == '0);
    assign memStall = req && !done;
    assign rdata    = mem[wordIdx];     // Valid in the completing cycle

    always_ff @(posedge clk) begin
        if (rst)
            waitLeft <= CntW'(`MEM_WAIT_CYCLES);
        else if (req && !done)
            waitLeft <= waitLeft - 1'b1;
        else
            waitLeft <= CntW'(`MEM_WAIT_CYCLES);   // Rearm for the next access
    end

    always_ff @(posedge clk) begin
        if (req && write && done)
            mem[wordIdx] <= wdata;
    end

    wordAligned: assert property (@(posedge clk) disable iff (rst) req |-> (addr[1:0] == 2'b00))
        else $error("misaligned data access at %h", addr);

endmodule

/* verilog/decodeUnit.sv */
`include "pipeCore_cfg.svh"

module decodeUnit (
    input  logic [`XLEN-1:0]       instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rdata1,
    input  logic [`XLEN-1:0]       rdata2,
    output pipePkg::idEx_t         idEx,
    output logic [`REG_ADDR_W-1:0] raddr1,
    output logic [`REG_ADDR_W-1:0] raddr2
);
    import isaPkg::*;
    import pipePkg::*;

    instrFields_t     fields;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immJ;

    assign fields = instrFields_t'(instr);
    assign raddr1 = fields.rs1;
    assign raddr2 = fields.rs2;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = immI;
        case (fields.opcode)
            opR: begin
                ctrl.regWrite = 1'b1;
                case (fields.funct3)
                    f3AddSub: ctrl.aluOp = (fields.funct7 == f7Sub) ? aluSub : aluAdd;
                    f3Slt:    ctrl.aluOp = aluSlt;
                    f3Xor:    ctrl.aluOp = aluXor;
                    f3Or:     ctrl.aluOp = aluOr;
                    f3And:    ctrl.aluOp = aluAnd;
                    default:  ctrl.regWrite = 1'b0;
                endcase
                // Only SUB may carry a nonzero funct7
                if (fields.funct7 != f7Base && !(fields.funct3 == f3AddSub && fields.funct7 == f7Sub))
                    ctrl = '0;
            end
            opImm: if (fields.funct3 == f3AddSub) begin   // ADDI only
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            opLoad: if (fields.funct3 == f3Word) begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            opStore: if (fields.funct3 == f3Word) begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                imm           = immS;
            end
            opBranch: if (fields.funct3 == f3Beq) begin
                ctrl.isBranch = 1'b1;
                imm           = immB;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.isJal    = 1'b1;
                imm           = immJ;
            end
            default: ctrl = '0;                 // Retires as a no-op
        endcase
    end

    assign idEx.valid  = 1'b1;  // Qualified by the fetch valid bit in the core
    assign idEx.pc     = pc;
    assign idEx.rs1    = fields.rs1;
    assign idEx.rs2    = fields.rs2;
    assign idEx.rd     = fields.rd;
    assign idEx.rs1Val = rdata1;
    assign idEx.rs2Val = rdata2;
    assign idEx.imm    = imm;
    assign idEx.ctrl   = ctrl;

endmodule

/* verilog/executeUnit.sv */
`include "pipeCore_cfg.svh"

module executeUnit (
    input  pipePkg::idEx_t   idEx,
    input  pipePkg::fwdSel_e forwardA,
    input  pipePkg::fwdSel_e forwardB,
    input  logic [`XLEN-1:0] memResult,
    input  logic [`XLEN-1:0] wbData,
    output pipePkg::exMem_t  exMem,
    output logic             redirect,
    output logic [`XLEN-1:0] target
);
    import isaPkg::*;
    import pipePkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] rs2Fwd;       // Also the store data
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;

    function automatic logic [`XLEN-1:0] fwdMux(input fwdSel_e sel,
                                                input logic [`XLEN-1:0] regVal,
                                                input logic [`XLEN-1:0] memVal,
                                                input logic [`XLEN-1:0] wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA    = fwdMux(forwardA, idEx.rs1Val, memResult, wbData);
    assign rs2Fwd = fwdMux(forwardB, idEx.rs2Val, memResult, wbData);
    assign opB    = idEx.ctrl.useImm ? idEx.imm : rs2Fwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            aluSlt:  aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluOut = opA + opB;
        endcase
    end

    // BEQ compares the forwarded registers, never the immediate
    assign redirect = idEx.valid
                      && (idEx.ctrl.isJal || (idEx.ctrl.isBranch && opA == rs2Fwd));
    assign target   = idEx.pc + idEx.imm;

    assign exMem.valid     = idEx.valid;
    assign exMem.pc        = idEx.pc;
    assign exMem.rd        = idEx.rd;
    assign exMem.result    = idEx.ctrl.isJal ? idEx.pc + `XLEN'(4) : aluOut;  // Link value
    assign exMem.storeData = rs2Fwd;
    assign exMem.ctrl      = idEx.ctrl;

endmodule

/* verilog/hazardUnit.sv */
`include "pipeCore_cfg.svh"

module hazardUnit (
    input  logic                clk,
    input  pipePkg::hazardReq_t req,
    output pipePkg::hazardCtl_t ctl
);
    import pipePkg::*;

    logic loadUse;

    // Memory stage wins over write-back, x0 is never forwarded
    function automatic fwdSel_e pickFwd(input logic [`REG_ADDR_W-1:0] rs, input hazardReq_t r);
        if (r.regWriteM && r.rdM != '0 && r.rdM == rs)
            return fwdMem;
        if (r.regWriteW && r.rdW != '0 && r.rdW == rs)
            return fwdWb;
        return fwdNone;
    endfunction

    assign loadUse = req.memReadE && (req.rdE != '0)
                     && (req.rdE == req.rs1D || req.rdE == req.rs2D);

    always_comb begin
        ctl          = '0;
        ctl.forwardA = pickFwd(req.rs1E, req);
        ctl.forwardB = pickFwd(req.rs2E, req);
        if (req.memStall) begin
            ctl.freeze = 1'b1;          // Everything holds
        end else if (loadUse) begin
            ctl.stallFD = 1'b1;
            ctl.flushE  = 1'b1;         // One bubble behind the load
        end else if (req.redirect) begin
            ctl.flushD = 1'b1;
            ctl.flushE = 1'b1;
        end
    end

    fwdAx0: assert property (@(posedge clk) (ctl.forwardA != fwdNone) |-> (req.rs1E != '0))
        else $error("forwardA selected for x0");
    fwdBx0: assert property (@(posedge clk) (ctl.forwardB != fwdNone) |-> (req.rs2E != '0))
        else $error("forwardB selected for x0");
    stallNotFlushD: assert property (@(posedge clk) ctl.stallFD |-> !ctl.flushD)
        else $error("stallFD and flushD both high");
    // Redirect must wait until the memory stage lets go
    freezeNoFlush: assert property (@(posedge clk) ctl.freeze |-> !(ctl.flushD || ctl.flushE))
        else $error("flush issued during freeze");

endmodule

/* verilog/isaPkg.sv */
package isaPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5
    } aluOp_e;

    // funct3 values that the decoder accepts
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;   // LW and SW
    localparam logic [2:0] f3Beq    = 3'b000;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    // R-type layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instrFields_t;

endpackage

/* verilog/pipeCore.sv */
`include "pipeCore_cfg.svh"

module pipeCore (
    input  logic             clk,
    input  logic             rst,
    output logic [`XLEN-1:0] imemAddr,
    input  logic [`XLEN-1:0] imemData,
    output pipePkg::retire_t retire
);
    import pipePkg::*;

    logic [`XLEN-1:0]       pc;
    logic                   ifIdValid;
    logic [`XLEN-1:0]       ifIdInstr;
    logic [`XLEN-1:0]       ifIdPc;
    idEx_t                  idExD;
    idEx_t                  idExQ;
    exMem_t                 exMemD;
    exMem_t                 exMemQ;
    memWb_t                 memWbQ;
    hazardReq_t             hzReq;
    hazardCtl_t             hzCtl;
    logic [`REG_ADDR_W-1:0] raddr1;
    logic [`REG_ADDR_W-1:0] raddr2;
    logic [`XLEN-1:0]       rdata1;
    logic [`XLEN-1:0]       rdata2;
    logic [`XLEN-1:0]       memRdata;
    logic [`XLEN-1:0]       memResult;
    logic [`XLEN-1:0]       target;
    logic                   redirect;
    logic                   memReq;
    logic                   memStall;

    assign imemAddr  = pc;
    assign memReq    = exMemQ.valid && (exMemQ.ctrl.memRead || exMemQ.ctrl.memWrite);
    assign memResult = exMemQ.ctrl.memRead ? memRdata : exMemQ.result;

    assign hzReq.rs1D      = raddr1;
    assign hzReq.rs2D      = raddr2;
    assign hzReq.rs1E      = idExQ.rs1;
    assign hzReq.rs2E      = idExQ.rs2;
    assign hzReq.rdE       = idExQ.rd;
    assign hzReq.memReadE  = idExQ.ctrl.memRead;
    assign hzReq.rdM       = exMemQ.rd;
    assign hzReq.regWriteM = exMemQ.ctrl.regWrite;
    assign hzReq.rdW       = memWbQ.rd;
    assign hzReq.regWriteW = memWbQ.regWrite;
    assign hzReq.redirect  = redirect;
    assign hzReq.memStall  = memStall;

    hazardUnit i_hazard (.clk(clk), .req(hzReq), .ctl(hzCtl));

    regFile i_regs (
        .clk(clk), .rst(rst),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
        .we(memWbQ.valid && memWbQ.regWrite), .waddr(memWbQ.rd), .wdata(memWbQ.wbData)
    );

    decodeUnit i_decode (
        .instr(ifIdValid ? ifIdInstr : '0), .pc(ifIdPc),   // Empty slot decodes as no-op
        .rdata1(rdata1), .rdata2(rdata2), .idEx(idExD), .raddr1(raddr1), .raddr2(raddr2)
    );

    executeUnit i_execute (
        .idEx(idExQ), .forwardA(hzCtl.forwardA), .forwardB(hzCtl.forwardB),
        .memResult(memResult), .wbData(memWbQ.wbData),
        .exMem(exMemD), .redirect(redirect), .target(target)
    );

    dataMemory i_dmem (
        .clk(clk), .rst(rst), .req(memReq), .write(exMemQ.ctrl.memWrite),
        .addr(exMemQ.result), .wdata(exMemQ.storeData), .rdata(memRdata), .memStall(memStall)
    );

    always_ff @(posedge clk) begin
        if (!hzCtl.freeze && !hzCtl.stallFD) begin
            ifIdInstr <= imemData;
            ifIdPc    <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= `RESET_PC;
            ifIdValid <= 1'b0;
            idExQ     <= '0;
            exMemQ    <= '0;
            memWbQ    <= '0;
        end else if (hzCtl.freeze) begin
            memWbQ <= '0;
            // The write-back source leaves now, so the held execute operands keep its value
            if (hzCtl.forwardA == fwdWb)
                idExQ.rs1Val <= memWbQ.wbData;
            if (hzCtl.forwardB == fwdWb)
                idExQ.rs2Val <= memWbQ.wbData;
        end else begin
            memWbQ.valid    <= exMemQ.valid;
            memWbQ.pc       <= exMemQ.pc;
            memWbQ.rd       <= exMemQ.rd;
            memWbQ.wbData   <= memResult;
            memWbQ.regWrite <= exMemQ.ctrl.regWrite;
            exMemQ          <= exMemD;
            if (hzCtl.flushE) begin
                idExQ <= '0;
            end else begin
                idExQ       <= idExD;
                idExQ.valid <= ifIdValid;
            end
            if (redirect)
                pc <= target;
            else if (!hzCtl.stallFD)
                pc <= pc + `XLEN'(4);
            if (hzCtl.flushD)
                ifIdValid <= 1'b0;      // Drop the wrong-path fetch
            else if (!hzCtl.stallFD)
                ifIdValid <= 1'b1;
        end
    end

    assign retire.valid    = memWbQ.valid;
    assign retire.pc       = memWbQ.pc;
    assign retire.rd       = memWbQ.rd;
    assign retire.data     = memWbQ.wbData;
    assign retire.regWrite = memWbQ.regWrite;

endmodule

/* verilog/pipeCore_cfg.svh */
`ifndef PIPECORE_CFG_SVH
`define PIPECORE_CFG_SVH

// Datapath and register index widths
`define XLEN            32
`define REG_ADDR_W      5

`define DMEM_WORDS      64       // Data memory depth in words
`define MEM_WAIT_CYCLES 2        // Stall cycles per load or store

`define RESET_PC        32'h0000_0000

`endif

/* verilog/pipePkg.sv */
`include "pipeCore_cfg.svh"

package pipePkg;

    // Same encoding as the classic ForwardAE select
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSel_e;

    typedef struct packed {
        logic           regWrite;
        logic           memRead;
        logic           memWrite;
        logic           isBranch;
        logic           isJal;
        logic           useImm;
        isaPkg::aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1Val;
        logic [`XLEN-1:0]       rs2Val;
        logic [`XLEN-1:0]       imm;
        ctrl_t                  ctrl;
    } idEx_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;     // ALU value, load/store address or link
        logic [`XLEN-1:0]       storeData;
        ctrl_t                  ctrl;
    } exMem_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       wbData;
        logic                   regWrite;
    } memWb_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1D;
        logic [`REG_ADDR_W-1:0] rs2D;
        logic [`REG_ADDR_W-1:0] rs1E;
        logic [`REG_ADDR_W-1:0] rs2E;
        logic [`REG_ADDR_W-1:0] rdE;
        logic                   memReadE;
        logic [`REG_ADDR_W-1:0] rdM;
        logic                   regWriteM;
        logic [`REG_ADDR_W-1:0] rdW;
        logic                   regWriteW;
        logic                   redirect;
        logic                   memStall;
    } hazardReq_t;

    typedef struct packed {
        fwdSel_e forwardA;
        fwdSel_e forwardB;
        logic    stallFD;
        logic    flushD;
        logic    flushE;
        logic    freeze;
    } hazardCtl_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic                   regWrite;
    } retire_t;

endpackage

/* verilog/regFile.sv */
`include "pipeCore_cfg.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata
);
    logic [`XLEN-1:0] regs [1:31];  // x0 has no storage

    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] ra);
        if (ra == '0)
            return '0;
        if (we && waddr == ra)
            return wdata;           // Same-cycle write bypass
        return regs[ra];
    endfunction

    always_comb rdata1 = readPort(raddr1);
    always_comb rdata2 = readPort(raddr2);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    x0StaysZero: assert property (@(posedge clk) disable iff (rst)
        (we && waddr == '0) |=> ((raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0)))
        else $error("write to x0 became visible");

endmodule
